// ==== dino_run.f ====
+incdir+test
hdl/dino_pkg.sv
hdl/video_timing.sv
hdl/motion_timer.sv
hdl/game_fsm.sv
hdl/obstacle_field.sv
hdl/score_counter.sv
hdl/pixel_painter.sv
hdl/dino_run_top.sv
test/dino_run_tb.sv

// ==== hdl/dino_pkg.sv ====
/* Raster, geometry, colour and game constants for a 1280x480 raster.
   Coordinates are 11 bits wide, so respawn positions past 2047 wrap modulo 2048 */
package dino_pkg;

    typedef logic [10:0] coord_t;
    typedef logic [9:0]  line_t;
    typedef logic [16:0] score_t;
    typedef logic [5:0]  lfsr_t;
    typedef logic [4:0]  pass_t;

    typedef enum logic {RUN, OVER} game_state_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        coord_t hcount;
        line_t  vcount;
        logic   active;
    } raster_t;

    typedef struct packed {
        coord_t cactus_x;
        coord_t group_x;
        coord_t lava_x;
        coord_t ptero_x;
    } obstacles_t;

    // Horizontal timing in pixel clocks
    localparam coord_t H_ACTIVE = 11'd1280;
    localparam coord_t H_FRONT  = 11'd32;
    localparam coord_t H_SYNC   = 11'd192;
    localparam coord_t H_BACK   = 11'd96;
    localparam coord_t H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // Vertical timing in lines
    localparam line_t V_ACTIVE = 10'd480;
    localparam line_t V_FRONT  = 10'd10;
    localparam line_t V_SYNC   = 10'd2;
    localparam line_t V_BACK   = 10'd33;
    localparam line_t V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam coord_t RUNNER_X = 11'd100;
    localparam coord_t GROUND_Y = 11'd248;
    localparam coord_t PTERO_Y  = 11'd200;
    localparam coord_t BOX      = 11'd32;
    localparam coord_t GROUP_W  = 11'd64;

    localparam coord_t CACTUS_SPAWN = 11'd1200;
    localparam coord_t GROUP_SPAWN  = 11'd1600;
    localparam coord_t LAVA_SPAWN   = 11'd1800;
    localparam coord_t PTERO_SPAWN  = 11'd1400;

    localparam coord_t BANNER_X = 11'd560;
    localparam coord_t BANNER_Y = 11'd200;
    localparam coord_t BANNER_W = 11'd160;
    localparam coord_t BANNER_H = 11'd32;

    localparam pass_t  SPEEDUP_PASSES = 5'd12;
    localparam score_t SCORE_MAX      = 17'd99999;
    localparam lfsr_t  LFSR_SEED      = 6'b101011;

    localparam rgb_t SKY        = '{r: 8'd135, g: 8'd206, b: 8'd235};
    localparam rgb_t RUNNER_RGB = '{r: 8'd83,  g: 8'd83,  b: 8'd83};
    localparam rgb_t CACTUS_RGB = '{r: 8'd34,  g: 8'd139, b: 8'd34};
    localparam rgb_t GROUP_RGB  = '{r: 8'd0,   g: 8'd100, b: 8'd0};
    localparam rgb_t LAVA_RGB   = '{r: 8'd255, g: 8'd69,  b: 8'd0};
    localparam rgb_t PTERO_RGB  = '{r: 8'd139, g: 8'd69,  b: 8'd19};
    localparam rgb_t BANNER_RGB = '{r: 8'd40,  g: 8'd40,  b: 8'd40};

endpackage

// ==== hdl/dino_run_top.sv ====
/* Runner game top level for a 1280x480 raster on a 50 MHz clock.
   Syncs are delayed one clock to line up with the registered colour */
`timescale 1ns/1ps

module dino_run_top #(
    parameter int unsigned TICK_CYCLES = 2_000_000
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             replay,
    output dino_pkg::rgb_t   vga_rgb,
    output logic             vga_hs,
    output logic             vga_vs,
    output logic             vga_blank_n,
    output logic             vga_sync_n,
    output logic             vga_clk,
    output dino_pkg::score_t score,
    output logic             game_over
);
    import dino_pkg::*;

    raster_t    raster;
    obstacles_t obstacles;
    logic       hs_n;
    logic       vs_n;
    logic       pix_clk;
    logic       run;
    logic       restart;
    logic       tick;

    video_timing u_video_timing (
        .clk     (clk),
        .reset   (reset),
        .raster  (raster),
        .hs_n    (hs_n),
        .vs_n    (vs_n),
        .pix_clk (pix_clk)
    );

    motion_timer #(.TICK_CYCLES(TICK_CYCLES)) u_motion_timer (
        .clk   (clk),
        .reset (reset),
        .run   (run),
        .tick  (tick)
    );

    game_fsm u_game_fsm (
        .clk       (clk),
        .reset     (reset),
        .obstacles (obstacles),
        .replay    (replay),
        .run       (run),
        .restart   (restart)
    );

    obstacle_field u_obstacle_field (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .restart   (restart),
        .obstacles (obstacles)
    );

    score_counter u_score_counter (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .score (score)
    );

    pixel_painter u_pixel_painter (
        .clk       (clk),
        .reset     (reset),
        .raster    (raster),
        .run       (run),
        .obstacles (obstacles),
        .rgb       (vga_rgb)
    );

    // Match the colour register stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vga_hs      <= 1'b1;
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
            vga_clk     <= 1'b0;
        end else begin
            vga_hs      <= hs_n;
            vga_vs      <= vs_n;
            vga_blank_n <= raster.active;
            vga_clk     <= pix_clk;
        end
    end

    assign vga_sync_n = 1'b0;
    assign game_over  = !run;

endmodule

// ==== hdl/game_fsm.sv ====
/* RUN/OVER state with collision against the ground obstacles.
   Replay is a level input sampled only in OVER */
`timescale 1ns/1ps

module game_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  dino_pkg::obstacles_t obstacles,
    input  logic                 replay,
    output logic                 run,
    output logic                 restart
);
    import dino_pkg::*;

    game_state_t state;
    logic        hit;

    // Ground obstacles share the runner rows, so only a strict x overlap decides
    function automatic logic overlaps(coord_t ox, coord_t w);
        return (12'(RUNNER_X) < 12'(ox) + 12'(w)) &&
               (12'(RUNNER_X) + 12'(BOX) > 12'(ox));
    endfunction

    assign hit = overlaps(obstacles.cactus_x, BOX) ||
                 overlaps(obstacles.group_x, GROUP_W) ||
                 overlaps(obstacles.lava_x, BOX);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= RUN;
            restart <= 1'b0;
        end else begin
            restart <= 1'b0;
            case (state)
                // Old positions still overlap while restart is in flight
                RUN: if (hit && !restart) state <= OVER;
                OVER: begin
                    if (replay) begin
                        state   <= RUN;
                        restart <= 1'b1;
                    end
                end
                default: state <= RUN;
            endcase
        end
    end

    assign run = (state == RUN);

endmodule

// ==== hdl/motion_timer.sv ====
/* One-cycle tick every TICK_CYCLES clocks while run is high.
   The count stays at zero while run is low, so a new round starts a full period */
`timescale 1ns/1ps

module motion_timer #(
    parameter int unsigned TICK_CYCLES = 2_000_000
) (
    input  logic clk,
    input  logic reset,
    input  logic run,
    output logic tick
);
    localparam int unsigned CW = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    logic [CW-1:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (!run || tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Last cycle of the period
    assign tick = run && (count == CW'(TICK_CYCLES - 1));

endmodule

// ==== hdl/obstacle_field.sv ====
/* Obstacle positions, respawn offsets from a 6-bit LFSR, wrap count and speed.
   Restart restores positions and speed; the LFSR keeps running across rounds */
`timescale 1ns/1ps

module obstacle_field (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  logic                 restart,
    output dino_pkg::obstacles_t obstacles
);
    import dino_pkg::*;

    localparam obstacles_t SPAWN = '{
        cactus_x: CACTUS_SPAWN,
        group_x:  GROUP_SPAWN,
        lava_x:   LAVA_SPAWN,
        ptero_x:  PTERO_SPAWN
    };

    coord_t speed;
    pass_t  passes;
    lfsr_t  lfsr;
    logic   wrapped;

    // Respawn off the right edge once at or below the speed, else move left
    function automatic coord_t step(coord_t x, coord_t spd, coord_t offset);
        if (x <= spd) begin
            return H_ACTIVE + offset;
        end
        return x - spd;
    endfunction

    assign wrapped = (obstacles.cactus_x <= speed) || (obstacles.group_x <= speed) ||
                     (obstacles.lava_x <= speed) || (obstacles.ptero_x <= speed);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            obstacles <= SPAWN;
            speed     <= 11'd1;
            passes    <= '0;
            lfsr      <= LFSR_SEED;
        end else if (restart) begin
            obstacles <= SPAWN;
            speed     <= 11'd1;
            passes    <= '0;
        end else if (tick) begin
            obstacles.cactus_x <= step(obstacles.cactus_x, speed, {1'b0, lfsr, 4'd0});
            obstacles.group_x  <= step(obstacles.group_x, speed, {1'b0, ~lfsr, 4'd0});
            obstacles.lava_x   <= step(obstacles.lava_x, speed, {1'b0, lfsr[3:0], 6'd0});
            obstacles.ptero_x  <= step(obstacles.ptero_x, speed, {1'b0, lfsr[5:2], 6'd0});

            // Taps at bits 5 and 4
            lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};

            if (passes >= SPEEDUP_PASSES) begin
                speed  <= speed + 11'd1;
                passes <= '0;
            end else if (wrapped) begin
                passes <= passes + 5'd1;
            end
        end
    end

endmodule

// ==== hdl/pixel_painter.sv ====
/* Registered colour per pixel, one clock behind the raster position.
   Objects are solid boxes; blanking outputs black */
`timescale 1ns/1ps

module pixel_painter (
    input  logic                 clk,
    input  logic                 reset,
    input  dino_pkg::raster_t    raster,
    input  logic                 run,
    input  dino_pkg::obstacles_t obstacles,
    output dino_pkg::rgb_t       rgb
);
    import dino_pkg::*;

    coord_t px;
    coord_t py;
    rgb_t   colour;

    function automatic logic in_box(coord_t x, coord_t y, coord_t ox, coord_t oy,
                                    coord_t w, coord_t h);
        return (x >= ox) && (12'(x) < 12'(ox) + 12'(w)) &&
               (y >= oy) && (12'(y) < 12'(oy) + 12'(h));
    endfunction

    assign px = raster.hcount;
    assign py = coord_t'(raster.vcount);

    always_comb begin
        colour = SKY;
        if (!run) begin
            // Game over screen shows only the replay banner
            if (in_box(px, py, BANNER_X, BANNER_Y, BANNER_W, BANNER_H)) begin
                colour = BANNER_RGB;
            end
        end else if (in_box(px, py, obstacles.ptero_x, PTERO_Y, BOX, BOX)) begin
            colour = PTERO_RGB;
        end else if (in_box(px, py, obstacles.lava_x, GROUND_Y, BOX, BOX)) begin
            colour = LAVA_RGB;
        end else if (in_box(px, py, obstacles.group_x, GROUND_Y, GROUP_W, BOX)) begin
            colour = GROUP_RGB;
        end else if (in_box(px, py, obstacles.cactus_x, GROUND_Y, BOX, BOX)) begin
            colour = CACTUS_RGB;
        end else if (in_box(px, py, RUNNER_X, GROUND_Y, BOX, BOX)) begin
            colour = RUNNER_RGB;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rgb <= '0;
        end else if (!raster.active) begin
            rgb <= '0;
        end else begin
            rgb <= colour;
        end
    end

endmodule

// ==== hdl/score_counter.sv ====
/* Score advances once per tick and wraps from SCORE_MAX to zero */
`timescale 1ns/1ps

module score_counter (
    input  logic             clk,
    input  logic             reset,
    input  logic             tick,
    output dino_pkg::score_t score
);
    import dino_pkg::*;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score <= '0;
        end else if (tick) begin
            score <= (score == SCORE_MAX) ? '0 : score + 17'd1;
        end
    end

endmodule

// ==== hdl/video_timing.sv ====
/* Pixel and line counters for the 1600x525 frame, one pixel per clock.
   Syncs are active low and combinational from the counters */
`timescale 1ns/1ps

module video_timing (
    input  logic              clk,
    input  logic              reset,
    output dino_pkg::raster_t raster,
    output logic              hs_n,
    output logic              vs_n,
    output logic              pix_clk
);
    import dino_pkg::*;

    coord_t hcount;
    line_t  vcount;
    logic   end_of_line;
    logic   end_of_frame;

    assign end_of_line  = (hcount == H_TOTAL - 11'd1);
    assign end_of_frame = (vcount == V_TOTAL - 10'd1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
            // Line count advances only at the end of each line
            vcount <= end_of_frame ? '0 : vcount + 10'd1;
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    assign raster.hcount = hcount;
    assign raster.vcount = vcount;
    assign raster.active = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);

    // Sync pulses sit after the front porch
    assign hs_n = !((hcount >= H_ACTIVE + H_FRONT) &&
                    (hcount < H_ACTIVE + H_FRONT + H_SYNC));
    assign vs_n = !((vcount >= V_ACTIVE + V_FRONT) &&
                    (vcount < V_ACTIVE + V_FRONT + V_SYNC));

    assign pix_clk = hcount[0];

endmodule

// ==== test/dino_run_model.svh ====
/* Reference rules of the runner game, included inside the testbench module after dino_pkg.
   Positions wrap modulo 2048 like the 11-bit coordinate registers */
`ifndef DINO_RUN_MODEL_SVH
`define DINO_RUN_MODEL_SVH

function automatic obstacles_t spawn_positions();
    obstacles_t o;
    o.cactus_x = CACTUS_SPAWN;
    o.group_x  = GROUP_SPAWN;
    o.lava_x   = LAVA_SPAWN;
    o.ptero_x  = PTERO_SPAWN;
    return o;
endfunction

// Offset past the right edge, 0 cactus, 1 group, 2 lava, 3 pterodactyl
function automatic int spawn_offset(int which, lfsr_t l);
    lfsr_t inv;
    inv = l ^ 6'h3f;
    case (which)
        0: return l * 16;
        1: return inv * 16;
        2: return l[3:0] * 64;
        default: return l[5:2] * 64;
    endcase
endfunction

function automatic coord_t move_obstacle(coord_t x, coord_t speed, int offset);
    int pos;
    if (x <= speed) begin
        pos = H_ACTIVE + offset;
    end else begin
        pos = x - speed;
    end
    return coord_t'(pos % 2048);
endfunction

function automatic lfsr_t next_lfsr(lfsr_t l);
    return {l[4:0], l[5] ^ l[4]};
endfunction

function automatic score_t next_score(score_t s);
    return (s == SCORE_MAX) ? '0 : s + 1;
endfunction

function automatic logic in_box(int x, int y, int ox, int oy, int w, int h);
    return (x >= ox) && (x < ox + w) && (y >= oy) && (y < oy + h);
endfunction

// Ground obstacles share the runner rows, so only x decides
function automatic logic collides(obstacles_t o);
    return ((o.cactus_x < RUNNER_X + BOX) && (o.cactus_x + 32 > RUNNER_X)) ||
           ((o.group_x < RUNNER_X + BOX) && (o.group_x + 64 > RUNNER_X)) ||
           ((o.lava_x < RUNNER_X + BOX) && (o.lava_x + 32 > RUNNER_X));
endfunction

function automatic rgb_t pixel_colour(int x, int y, logic run, obstacles_t o);
    if (!run) begin
        return in_box(x, y, BANNER_X, BANNER_Y, BANNER_W, BANNER_H) ? BANNER_RGB : SKY;
    end
    if (in_box(x, y, o.ptero_x, PTERO_Y, BOX, BOX)) return PTERO_RGB;
    if (in_box(x, y, o.lava_x, GROUND_Y, BOX, BOX)) return LAVA_RGB;
    if (in_box(x, y, o.group_x, GROUND_Y, GROUP_W, BOX)) return GROUP_RGB;
    if (in_box(x, y, o.cactus_x, GROUND_Y, BOX, BOX)) return CACTUS_RGB;
    if (in_box(x, y, RUNNER_X, GROUND_Y, BOX, BOX)) return RUNNER_RGB;
    return SKY;
endfunction

`endif

// ==== test/dino_run_tb.sv ====
/* Testbench for dino_run_top with a 16-cycle motion tick.
   A cycle model on the posedge predicts score, game state and video outputs; checks on negedge */
`timescale 1ns/1ps

module dino_run_tb;
    import dino_pkg::*;

    `include "dino_run_model.svh"

    localparam int TICK  = 16;
    localparam int FRAME = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int LIMIT = 3 * FRAME + 2000 * TICK;

    logic   clk;
    logic   reset;
    logic   replay;
    rgb_t   vga_rgb;
    logic   vga_hs;
    logic   vga_vs;
    logic   vga_blank_n;
    logic   vga_sync_n;
    logic   vga_clk;
    score_t score;
    logic   game_over;

    // Model state
    int         m_count;
    logic       m_run;
    logic       m_restart;
    obstacles_t m_obs;
    coord_t     m_speed;
    pass_t      m_passes;
    lfsr_t      m_lfsr;
    score_t     m_score;
    rgb_t       m_rgb;
    logic       m_blank_n;
    logic       m_vclk;
    int         m_h;
    int         m_v;
    int         m_px;
    int         m_py;
    int         m_cycle;

    int     cycles;
    int     errors;
    int     test_errors;
    int     tests;
    int     failed;
    int     n;
    int     delay;
    score_t held;
    integer seed;
    string  test_name;

    dino_run_top #(.TICK_CYCLES(TICK)) u_dino_run_top (
        .clk         (clk),
        .reset       (reset),
        .replay      (replay),
        .vga_rgb     (vga_rgb),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n),
        .vga_clk     (vga_clk),
        .score       (score),
        .game_over   (game_over)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            test_errors++;
            if (errors <= 20) begin
                $display("Fail %s %s expected %0h actual %0h", test_name, what, expected, actual);
            end
            if (errors == 20) begin
                $display("Too many mismatches, later ones are only counted");
            end
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        if (test_errors != 0) begin
            failed++;
        end
        $display("%s: %s", test_name, (test_errors == 0) ? "ok" : "failed");
    endtask

    // Returns at the negedge where the colour of raster (x, y) is on the outputs
    task automatic wait_for_pixel(input int x, input int y);
        @(negedge clk);
        while (m_px != x || m_py != y) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin : cycle_model
        logic tick;
        logic wrapped;
        logic next_run;
        logic next_restart;
        if (reset) begin
            m_count   = 0;
            m_run     = 1'b1;
            m_restart = 1'b0;
            m_obs     = spawn_positions();
            m_speed   = 11'd1;
            m_passes  = '0;
            m_lfsr    = LFSR_SEED;
            m_score   = '0;
            m_rgb     = '0;
            m_blank_n = 1'b0;
            m_vclk    = 1'b0;
            m_h       = 0;
            m_v       = 0;
            m_px      = -1;
            m_py      = -1;
            m_cycle   = 0;
        end else begin
            m_cycle++;
            m_px      = m_h;
            m_py      = m_v;
            m_blank_n = (m_h < H_ACTIVE) && (m_v < V_ACTIVE);
            // Pixel clock is the lowest bit of the pixel count
            m_vclk    = (m_h % 2) != 0;
            m_rgb     = m_blank_n ? pixel_colour(m_h, m_v, m_run, m_obs) : '0;
            m_h++;
            if (m_h == H_TOTAL) begin
                m_h = 0;
                m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
            end
            tick         = m_run && (m_count == TICK - 1);
            next_run     = m_run;
            next_restart = 1'b0;
            // Positions of the old round are not judged until restored
            if (m_run && !m_restart && collides(m_obs)) begin
                next_run = 1'b0;
            end else if (!m_run && replay) begin
                next_run     = 1'b1;
                next_restart = 1'b1;
            end
            m_count = (m_run && !tick) ? m_count + 1 : 0;
            if (m_restart) begin
                m_obs    = spawn_positions();
                m_speed  = 11'd1;
                m_passes = '0;
            end else if (tick) begin
                wrapped = (m_obs.cactus_x <= m_speed) || (m_obs.group_x <= m_speed) ||
                          (m_obs.lava_x <= m_speed) || (m_obs.ptero_x <= m_speed);
                m_obs.cactus_x = move_obstacle(m_obs.cactus_x, m_speed, spawn_offset(0, m_lfsr));
                m_obs.group_x  = move_obstacle(m_obs.group_x, m_speed, spawn_offset(1, m_lfsr));
                m_obs.lava_x   = move_obstacle(m_obs.lava_x, m_speed, spawn_offset(2, m_lfsr));
                m_obs.ptero_x  = move_obstacle(m_obs.ptero_x, m_speed, spawn_offset(3, m_lfsr));
                m_lfsr = next_lfsr(m_lfsr);
                if (m_passes >= SPEEDUP_PASSES) begin
                    m_speed  = m_speed + 1;
                    m_passes = '0;
                end else if (wrapped) begin
                    m_passes = m_passes + 1;
                end
            end
            if (tick) begin
                m_score = next_score(m_score);
            end
            m_run     = next_run;
            m_restart = next_restart;
        end
    end

    // Compare process
    always @(negedge clk) begin
        if (!reset) begin
            check("score", m_score, score);
            check("game_over", !m_run, game_over);
            check("colour", m_rgb, vga_rgb);
            check("blank_n", m_blank_n, vga_blank_n);
            check("pixel clock", m_vclk, vga_clk);
            check("sync_n", 0, vga_sync_n);
        end
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the game did not reach the expected state",
                 cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        seed        = 54;
        errors      = 0;
        tests       = 0;
        failed      = 0;
        test_errors = 0;
        test_name   = "reset";
        replay      = 1'b0;
        reset       = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        begin_test("pixels_start");
        wait_for_pixel(0, 0);
        check("sky", SKY, vga_rgb);
        wait_for_pixel(H_ACTIVE + 8, 0);
        check("blanking", 0, vga_rgb);
        end_test();

        begin_test("video_timing");
        while (vga_hs) @(negedge clk);
        check("hsync start", H_ACTIVE + H_FRONT + 1, m_cycle);
        repeat (4) begin
            n = 0;
            while (!vga_hs) begin
                @(negedge clk);
                n++;
            end
            check("hsync low", H_SYNC, n);
            n = 0;
            while (vga_hs) begin
                @(negedge clk);
                n++;
            end
            check("hsync high", int'(H_TOTAL) - int'(H_SYNC), n);
        end
        n = 0;
        repeat (FRAME) begin
            @(negedge clk);
            if (!vga_vs) begin
                n++;
            end
        end
        check("vsync low", int'(V_SYNC) * int'(H_TOTAL), n);
        end_test();

        begin_test("game_over");
        while (!game_over) @(negedge clk);
        check("score at game over", m_score, score);
        held = score;
        repeat (100) @(negedge clk);
        check("score held", held, score);
        end_test();

        begin_test("pixels_over");
        wait_for_pixel(600, 210);
        check("banner", BANNER_RGB, vga_rgb);
        wait_for_pixel(110, 260);
        check("runner spot", SKY, vga_rgb);
        end_test();

        // Line 255 leaves room for the runner checks before the next crash
        begin_test("replay");
        wait_for_pixel(0, 255);
        delay = {$random(seed)} % 512;
        repeat (delay) @(negedge clk);
        check("over before replay", 1, game_over);
        replay = 1'b1;
        @(negedge clk);
        replay = 1'b0;
        check("game_over falls", 0, game_over);
        end_test();

        begin_test("pixels_run");
        wait_for_pixel(110, 260);
        check("runner", RUNNER_RGB, vga_rgb);
        wait_for_pixel(H_ACTIVE + 8, 260);
        check("blanking", 0, vga_rgb);
        end_test();

        begin_test("game_over_again");
        while (!game_over) @(negedge clk);
        check("score at game over", m_score, score);
        end_test();

        $display("%0d tests, %0d failed, %0d mismatches", tests, failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
